// ==== rtl/vga_pkg.sv ====
package vga_pkg;

    // ==============================
    // Raster types
    // ==============================

    typedef logic [9:0] coord_t;    // Pixel counter value

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // Full video output, 27 bits
    typedef struct packed {
        logic hsync_n;
        logic vsync_n;
        logic blank_n;
        rgb_t rgb;
    } vga_out_t;

endpackage

// ==== rtl/game_pkg.sv ====
package game_pkg;

    // ==============================
    // Game types
    // ==============================

    typedef logic [1:0]  lane_t;
    typedef logic [9:0]  note_y_t;      // Top edge in field rows
    typedef logic [7:0]  score_t;
    typedef logic [9:0]  combo_t;
    typedef logic [13:0] frame_cnt_t;

    typedef enum logic [1:0] {
        JUDGE_MISS    = 2'd0,
        JUDGE_OK      = 2'd1,
        JUDGE_GOOD    = 2'd2,
        JUDGE_PERFECT = 2'd3
    } judge_t;

    typedef enum logic [1:0] {
        GAME_ACTIVE = 2'd0,
        GAME_WON    = 2'd1,
        GAME_LOST   = 2'd2
    } game_state_t;

    typedef struct packed {
        logic   valid;
        judge_t judge;
    } judge_evt_t;

    typedef struct packed {
        score_t      score;
        judge_t      last_judge;
        game_state_t state;
    } game_status_t;

    // ==============================
    // Geometry
    // ==============================

    // Lane l spans LANE_X[l] up to LANE_X[l+1]
    localparam logic [9:0] LANE_X [5] = '{10'd40, 10'd160, 10'd280, 10'd400, 10'd520};

    localparam note_y_t HIT_Y_START  = 10'd360;
    localparam note_y_t HIT_Y_END    = 10'd460;
    localparam note_y_t HIT_Y_CENTER = 10'd410;
    localparam note_y_t PERFECT_DIST = 10'd4;
    localparam note_y_t GOOD_DIST    = 10'd10;
    localparam note_y_t NOTE_HEIGHT  = 10'd32;
    localparam note_y_t FIELD_BOTTOM = 10'd512;    // Notes below this are lost

    localparam logic [9:0] SCORE_BAR_X0     = 10'd580;
    localparam logic [9:0] SCORE_BAR_X1     = 10'd600;
    localparam logic [9:0] SCORE_BAR_BOTTOM = 10'd480;

    // ==============================
    // Pool and scoring
    // ==============================

    localparam int N_NOTES     = 16;
    localparam int SPAWN_DELAY = 30;    // Frames before the first note

    localparam score_t SCORE_33     = 8'd85;
    localparam score_t SCORE_66     = 8'd170;
    localparam score_t SCORE_MAX    = 8'd255;
    localparam score_t MISS_PENALTY = 8'd2;

endpackage

// ==== rtl/vga_timing.sv ====
`timescale 1ns/1ns

module vga_timing #(
    parameter int h_visible = 640,
    parameter int h_front   = 16,
    parameter int h_sync    = 96,
    parameter int h_back    = 48,
    parameter int v_visible = 480,
    parameter int v_front   = 10,
    parameter int v_sync    = 2,
    parameter int v_back    = 33
) (
    input  logic            pix_clk,
    input  logic            reset,
    output vga_pkg::coord_t h_cnt_o,
    output vga_pkg::coord_t v_cnt_o,
    output logic            frame_tick_o,
    output logic            hsync_n_o,
    output logic            vsync_n_o,
    output logic            blank_n_o
);
    import vga_pkg::*;

    localparam coord_t H_LAST   = coord_t'(h_visible + h_front + h_sync + h_back - 1);
    localparam coord_t V_LAST   = coord_t'(v_visible + v_front + v_sync + v_back - 1);
    localparam coord_t HS_START = coord_t'(h_visible + h_front);
    localparam coord_t HS_END   = coord_t'(h_visible + h_front + h_sync);
    localparam coord_t VS_START = coord_t'(v_visible + v_front);
    localparam coord_t VS_END   = coord_t'(v_visible + v_front + v_sync);

    assign frame_tick_o = (h_cnt_o == '0) && (v_cnt_o == '0);

    always_ff @(posedge pix_clk or posedge reset) begin
        if (reset) begin
            h_cnt_o <= '0;
            v_cnt_o <= '0;
        end else if (h_cnt_o == H_LAST) begin
            h_cnt_o <= '0;
            v_cnt_o <= (v_cnt_o == V_LAST) ? '0 : v_cnt_o + 10'd1;    // Step once per line
        end else begin
            h_cnt_o <= h_cnt_o + 10'd1;
        end
    end

    // Syncs and blank lag the counters by one pixel
    always_ff @(posedge pix_clk or posedge reset) begin
        if (reset) begin
            hsync_n_o <= 1'b1;
            vsync_n_o <= 1'b1;
            blank_n_o <= 1'b0;
        end else begin
            hsync_n_o <= !((h_cnt_o >= HS_START) && (h_cnt_o < HS_END));
            vsync_n_o <= !((v_cnt_o >= VS_START) && (v_cnt_o < VS_END));
            blank_n_o <= (h_cnt_o < coord_t'(h_visible)) && (v_cnt_o < coord_t'(v_visible));
        end
    end

endmodule

// ==== rtl/game_timer.sv ====
`timescale 1ns/1ns

module game_timer #(
    parameter int max_frames = 10800
) (
    input  logic                  pix_clk,
    input  logic                  reset,
    input  logic                  frame_tick_i,
    input  game_pkg::score_t      score_i,
    output game_pkg::game_state_t state_o,
    output game_pkg::frame_cnt_t  frames_o
);
    import game_pkg::*;

    localparam frame_cnt_t FRAME_LIMIT = frame_cnt_t'(max_frames);

    // Won and lost hold until reset
    always_ff @(posedge pix_clk or posedge reset) begin
        if (reset) begin
            state_o  <= GAME_ACTIVE;
            frames_o <= '0;
        end else if (frame_tick_i && (state_o == GAME_ACTIVE)) begin
            if (score_i == SCORE_MAX) begin
                state_o <= GAME_WON;
            end else if (frames_o < FRAME_LIMIT) begin
                frames_o <= frames_o + 14'd1;
            end else begin
                state_o <= GAME_LOST;    // Out of time
            end
        end
    end

endmodule

// ==== rtl/note_field.sv ====
`timescale 1ns/1ns

module note_field (
    input  logic                                      pix_clk,
    input  logic                                      reset,
    input  logic                                      frame_tick_i,
    input  game_pkg::game_state_t                     state_i,
    input  game_pkg::score_t                          score_i,
    input  logic [3:0]                                btn_i,
    output game_pkg::judge_evt_t                      evt_o,
    output logic                                      miss_o,
    output logic [game_pkg::N_NOTES-1:0]              note_active_o,
    output game_pkg::lane_t [game_pkg::N_NOTES-1:0]   note_lane_o,
    output game_pkg::note_y_t [game_pkg::N_NOTES-1:0] note_y_o
);
    import game_pkg::*;

    localparam int IDX_W = $clog2(N_NOTES);

    logic [3:0]            prev_btn;
    logic [4:0]            spawn_cnt;
    lane_t                 spawn_lane;
    logic                  tick_active;
    logic [3:0]            press;
    note_y_t               speed;
    logic [4:0]            spawn_reload;
    logic                  free_found;
    logic [IDX_W-1:0]      free_idx;
    logic                  do_spawn;
    logic [N_NOTES-1:0]    fall_off;
    logic [N_NOTES-1:0]    hit_mask;
    logic [3:0]            lane_hit;
    logic [3:0][IDX_W-1:0] lane_idx;
    judge_t [3:0]          lane_judge;
    judge_t                hit_judge;

    assign tick_active = frame_tick_i && (state_i == GAME_ACTIVE);
    assign press       = btn_i & ~prev_btn;    // Rising edges since last tick
    assign do_spawn    = tick_active && (spawn_cnt == 5'd0) && free_found;

    // Difficulty follows the score
    always_comb begin
        if (score_i < SCORE_33) begin
            speed        = 10'd2;
            spawn_reload = 5'd28;
        end else if (score_i < SCORE_66) begin
            speed        = 10'd4;
            spawn_reload = 5'd22;
        end else begin
            speed        = 10'd6;
            spawn_reload = 5'd16;
        end
    end

    // Lowest free slot, fall-off detection
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = N_NOTES - 1; i >= 0; i--) begin
            fall_off[i] = note_active_o[i] && (note_y_o[i] > FIELD_BOTTOM);
            if (!note_active_o[i]) begin
                free_found = 1'b1;
                free_idx   = IDX_W'(i);
            end
        end
    end

    // ==============================
    // Hit judging per lane
    // ==============================
    always_comb begin : judge_search
        note_y_t best_diff;
        note_y_t center;
        note_y_t diff;
        hit_mask = '0;
        for (int l = 0; l < 4; l++) begin
            lane_hit[l]   = 1'b0;
            lane_idx[l]   = '0;
            lane_judge[l] = JUDGE_MISS;
            best_diff     = '1;
            for (int i = 0; i < N_NOTES; i++) begin
                center = note_y_o[i] + (NOTE_HEIGHT >> 1);
                diff   = (center > HIT_Y_CENTER) ? center - HIT_Y_CENTER : HIT_Y_CENTER - center;
                if (press[l] && note_active_o[i] && (note_lane_o[i] == lane_t'(l)) &&
                    (note_y_o[i] + NOTE_HEIGHT >= HIT_Y_START) &&
                    (note_y_o[i] <= HIT_Y_END) && (diff < best_diff)) begin
                    lane_hit[l] = 1'b1;
                    lane_idx[l] = IDX_W'(i);
                    best_diff   = diff;
                end
            end
            if (lane_hit[l]) begin
                hit_mask[lane_idx[l]] = 1'b1;
                if (best_diff <= PERFECT_DIST)
                    lane_judge[l] = JUDGE_PERFECT;
                else if (best_diff <= GOOD_DIST)
                    lane_judge[l] = JUDGE_GOOD;
                else
                    lane_judge[l] = JUDGE_OK;
            end
        end
    end

    // Lowest lane hit is the one reported
    always_comb begin
        hit_judge = JUDGE_MISS;
        for (int l = 3; l >= 0; l--) begin
            if (lane_hit[l])
                hit_judge = lane_judge[l];
        end
    end

    // ==============================
    // Pool control and reports
    // ==============================
    always_ff @(posedge pix_clk or posedge reset) begin
        if (reset) begin
            prev_btn      <= '0;
            spawn_cnt     <= 5'(SPAWN_DELAY);
            spawn_lane    <= '0;
            note_active_o <= '0;
            evt_o         <= '0;
            miss_o        <= 1'b0;
        end else begin
            evt_o  <= '0;
            miss_o <= 1'b0;
            if (frame_tick_i)
                prev_btn <= btn_i;
            if (tick_active) begin
                note_active_o <= note_active_o & ~fall_off & ~hit_mask;
                if (do_spawn) begin
                    note_active_o[free_idx] <= 1'b1;
                    spawn_lane              <= spawn_lane + 2'd1;    // Strict rotation
                end
                spawn_cnt    <= (spawn_cnt == 5'd0) ? spawn_reload : spawn_cnt - 5'd1;
                evt_o.valid  <= |lane_hit;
                evt_o.judge  <= hit_judge;
                miss_o       <= !(|lane_hit) && ((|fall_off) || (|(press & ~lane_hit)));
            end
        end
    end

    // Note positions and lanes
    always_ff @(posedge pix_clk) begin
        if (tick_active) begin
            for (int i = 0; i < N_NOTES; i++)
                note_y_o[i] <= note_y_o[i] + speed;
            if (do_spawn) begin
                note_y_o[free_idx]    <= '0;
                note_lane_o[free_idx] <= spawn_lane;
            end
        end
    end

endmodule

// ==== rtl/score_keeper.sv ====
`timescale 1ns/1ns

module score_keeper (
    input  logic                 pix_clk,
    input  logic                 reset,
    input  game_pkg::judge_evt_t evt_i,
    input  logic                 miss_i,
    output game_pkg::score_t     score_o,
    output game_pkg::judge_t     last_judge_o,
    output logic [1:0]           combo_level_o
);
    import game_pkg::*;

    combo_t     combo;
    logic [4:0] base_pts;
    logic [4:0] mult;       // Tenths
    logic [4:0] scaled;
    score_t     gain;

    always_comb begin
        if (combo >= 10'd20)
            combo_level_o = 2'd2;
        else if (combo >= 10'd10)
            combo_level_o = 2'd1;
        else
            combo_level_o = 2'd0;
    end

    always_comb begin
        case (evt_i.judge)
            JUDGE_PERFECT: base_pts = 5'd2;
            JUDGE_GOOD:    base_pts = 5'd1;
            default:       base_pts = 5'd0;
        endcase
        case (combo_level_o)
            2'd2:    mult = 5'd12;
            2'd1:    mult = 5'd11;
            default: mult = 5'd10;
        endcase
    end

    // Rounded base * mult / 10
    assign scaled = base_pts * mult + 5'd5;
    assign gain   = score_t'(scaled / 5'd10);

    always_ff @(posedge pix_clk or posedge reset) begin
        if (reset) begin
            score_o      <= '0;
            combo        <= '0;
            last_judge_o <= JUDGE_MISS;
        end else if (evt_i.valid) begin
            score_o      <= (score_o > SCORE_MAX - gain) ? SCORE_MAX : score_o + gain;
            combo        <= (combo == '1) ? combo : combo + 10'd1;
            last_judge_o <= evt_i.judge;
        end else if (miss_i) begin
            score_o      <= (score_o > MISS_PENALTY) ? score_o - MISS_PENALTY : '0;
            combo        <= '0;
            last_judge_o <= JUDGE_MISS;
        end
    end

endmodule

// ==== rtl/pixel_render.sv ====
`timescale 1ns/1ns

module pixel_render (
    input  logic                                      pix_clk,
    input  logic                                      reset,
    input  vga_pkg::coord_t                           h_cnt_i,
    input  vga_pkg::coord_t                           v_cnt_i,
    input  logic                                      blank_n_i,
    input  game_pkg::game_state_t                     state_i,
    input  game_pkg::score_t                          score_i,
    input  game_pkg::judge_t                          last_judge_i,
    input  logic [game_pkg::N_NOTES-1:0]              note_active_i,
    input  game_pkg::lane_t [game_pkg::N_NOTES-1:0]   note_lane_i,
    input  game_pkg::note_y_t [game_pkg::N_NOTES-1:0] note_y_i,
    output vga_pkg::rgb_t                             rgb_o
);
    import vga_pkg::*;
    import game_pkg::*;

    localparam rgb_t LANE_TINT [4] = '{'{8'd40, 8'd0, 8'd0}, '{8'd40, 8'd40, 8'd0},
                                       '{8'd0, 8'd40, 8'd0}, '{8'd0, 8'd0, 8'd40}};
    localparam rgb_t NOTE_COL  [4] = '{'{8'd255, 8'd0, 8'd0}, '{8'd255, 8'd255, 8'd0},
                                       '{8'd0, 8'd255, 8'd0}, '{8'd0, 8'd0, 8'd255}};

    logic [3:0] in_lane;
    logic       in_band;
    coord_t     band_dist;
    rgb_t       colour;
    rgb_t       rgb_q;

    assign in_band   = (v_cnt_i >= HIT_Y_START) && (v_cnt_i < HIT_Y_END);
    assign band_dist = (v_cnt_i > HIT_Y_CENTER) ? v_cnt_i - HIT_Y_CENTER : HIT_Y_CENTER - v_cnt_i;

    always_comb begin
        for (int l = 0; l < 4; l++)
            in_lane[l] = (h_cnt_i >= LANE_X[l]) && (h_cnt_i < LANE_X[l+1]);
    end

    // ==============================
    // Layered colour, last wins
    // ==============================
    always_comb begin
        colour = '{8'd10, 8'd10, 8'd10};
        if (state_i == GAME_WON) begin
            colour = '{8'd0, 8'd255, 8'd0};
        end else if (state_i == GAME_LOST) begin
            colour = '{8'd255, 8'd0, 8'd0};
        end else begin
            for (int l = 0; l < 4; l++) begin
                if (in_lane[l])
                    colour = LANE_TINT[l];
            end
            if (in_band) begin
                colour = '{8'd30, 8'd30, 8'd60};                               // Ok band
                if (band_dist <= GOOD_DIST)
                    colour = '{8'd200, 8'd200, 8'd40};
                if (band_dist <= PERFECT_DIST)
                    colour = '{8'd255, 8'd255, 8'd255};
            end
            for (int i = 0; i < N_NOTES; i++) begin
                if (note_active_i[i] && in_lane[note_lane_i[i]] && (v_cnt_i >= note_y_i[i]) &&
                    (v_cnt_i < note_y_i[i] + NOTE_HEIGHT))
                    colour = NOTE_COL[note_lane_i[i]];
            end
            // Score bar grows upward from the bottom edge
            if ((h_cnt_i >= SCORE_BAR_X0) && (h_cnt_i < SCORE_BAR_X1) &&
                (v_cnt_i >= SCORE_BAR_BOTTOM - {2'b00, score_i}) &&
                (v_cnt_i < SCORE_BAR_BOTTOM)) begin
                case (last_judge_i)
                    JUDGE_PERFECT: colour = '{8'd255, 8'd80, 8'd255};
                    JUDGE_GOOD:    colour = '{8'd80, 8'd255, 8'd255};
                    JUDGE_OK:      colour = '{8'd80, 8'd255, 8'd80};
                    default:       colour = '{8'd40, 8'd40, 8'd40};
                endcase
            end
        end
    end

    always_ff @(posedge pix_clk or posedge reset) begin
        if (reset)
            rgb_q <= '0;
        else
            rgb_q <= colour;
    end

    assign rgb_o = blank_n_i ? rgb_q : '0;    // Black outside the visible area

endmodule

// ==== rtl/rhythm_top.sv ====
`timescale 1ns/1ns

module rhythm_top #(
    parameter int h_visible  = 640,
    parameter int h_front    = 16,
    parameter int h_sync     = 96,
    parameter int h_back     = 48,
    parameter int v_visible  = 480,
    parameter int v_front    = 10,
    parameter int v_sync     = 2,
    parameter int v_back     = 33,
    parameter int max_frames = 10800
) (
    input  logic                   pix_clk,
    input  logic                   reset,
    input  logic [3:0]             btn_i,
    output vga_pkg::vga_out_t      vga_o,
    output game_pkg::game_status_t status_o
);
    import vga_pkg::*;
    import game_pkg::*;

    coord_t             h_cnt;
    coord_t             v_cnt;
    logic               frame_tick;
    logic               hsync_n;
    logic               vsync_n;
    logic               blank_n;
    game_state_t        game_state;
    score_t             score;
    judge_t             last_judge;
    judge_evt_t         evt;
    logic               miss;
    logic [N_NOTES-1:0] note_active;
    lane_t [N_NOTES-1:0]   note_lane;
    note_y_t [N_NOTES-1:0] note_y;
    rgb_t               rgb;

    // ==============================
    // Raster
    // ==============================
    vga_timing #(
        .h_visible(h_visible), .h_front(h_front), .h_sync(h_sync), .h_back(h_back),
        .v_visible(v_visible), .v_front(v_front), .v_sync(v_sync), .v_back(v_back)
    ) i_timing (
        .pix_clk(pix_clk), .reset(reset), .h_cnt_o(h_cnt), .v_cnt_o(v_cnt),
        .frame_tick_o(frame_tick), .hsync_n_o(hsync_n), .vsync_n_o(vsync_n),
        .blank_n_o(blank_n)
    );

    // ==============================
    // Game
    // ==============================
    game_timer #(.max_frames(max_frames)) i_timer (
        .pix_clk(pix_clk), .reset(reset), .frame_tick_i(frame_tick), .score_i(score),
        .state_o(game_state), .frames_o()
    );

    note_field i_notes (
        .pix_clk(pix_clk), .reset(reset), .frame_tick_i(frame_tick), .state_i(game_state),
        .score_i(score), .btn_i(btn_i), .evt_o(evt), .miss_o(miss),
        .note_active_o(note_active), .note_lane_o(note_lane), .note_y_o(note_y)
    );

    score_keeper i_score (
        .pix_clk(pix_clk), .reset(reset), .evt_i(evt), .miss_i(miss), .score_o(score),
        .last_judge_o(last_judge), .combo_level_o()
    );

    pixel_render i_render (
        .pix_clk(pix_clk), .reset(reset), .h_cnt_i(h_cnt), .v_cnt_i(v_cnt),
        .blank_n_i(blank_n), .state_i(game_state), .score_i(score),
        .last_judge_i(last_judge), .note_active_i(note_active), .note_lane_i(note_lane),
        .note_y_i(note_y), .rgb_o(rgb)
    );

    assign vga_o    = '{hsync_n: hsync_n, vsync_n: vsync_n, blank_n: blank_n, rgb: rgb};
    assign status_o = '{score: score, last_judge: last_judge, state: game_state};

endmodule

// ==== verif/rhythm_assertions.sv ====
`timescale 1ns/1ns

module rhythm_assertions #(
    parameter int h_sync = 96
) (
    input logic                  pix_clk,
    input logic                  reset,
    input logic                  hsync_n_i,
    input logic                  blank_n_i,
    input game_pkg::game_state_t state_i
);
    import game_pkg::*;

    int low_cnt;    // Cycles of the current hsync pulse

    always_ff @(posedge pix_clk or posedge reset) begin
        if (reset)
            low_cnt <= 0;
        else if (!hsync_n_i)
            low_cnt <= low_cnt + 1;
        else
            low_cnt <= 0;
    end

    // ==============================
    // Raster and game state
    // ==============================
    hsync_width: assert property (@(posedge pix_clk) disable iff (reset)
        $rose(hsync_n_i) |-> (low_cnt == h_sync))
        else $error("hsync pulse lasted %0d cycles", low_cnt);

    blank_in_sync: assert property (@(posedge pix_clk) disable iff (reset)
        !hsync_n_i |-> !blank_n_i)
        else $error("blank_n high during hsync");

    // Won and lost are final
    state_final: assert property (@(posedge pix_clk) disable iff (reset)
        (state_i != GAME_ACTIVE) |=> (state_i != GAME_ACTIVE))
        else $error("game state returned to active");

endmodule

// Raster checks, state input held at active
bind vga_timing rhythm_assertions #(.h_sync(h_sync)) i_sync_checks (
    .pix_clk(pix_clk), .reset(reset), .hsync_n_i(hsync_n_o), .blank_n_i(blank_n_o),
    .state_i(game_pkg::GAME_ACTIVE)
);

// State checks, sync inputs held inactive
bind game_timer rhythm_assertions i_state_checks (
    .pix_clk(pix_clk), .reset(reset), .hsync_n_i(1'b1), .blank_n_i(1'b0),
    .state_i(state_o)
);

// ==== verif/rhythm_tb.sv ====
`timescale 1ns/1ns

module rhythm_tb;
    import vga_pkg::*;
    import game_pkg::*;

    // ==============================
    // Small raster of 40 x 32 total
    // ==============================
    localparam int H_VISIBLE    = 32;
    localparam int V_VISIBLE    = 24;
    localparam int PORCH        = 2;
    localparam int SYNC_W       = 4;
    localparam int H_TOTAL      = H_VISIBLE + 2 * PORCH + SYNC_W;
    localparam int V_TOTAL      = V_VISIBLE + 2 * PORCH + SYNC_W;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int MAX_FRAMES   = 400;

    // Note timing at 2 rows per frame in ticks after the spawn tick
    localparam int FIRST_SPAWN = 30;     // Lane 0
    localparam int SPAWN_GAP   = 29;     // Reload of 28 plus the expiring tick
    localparam int HIT_TICKS   = 198;    // Centre 16 rows down reaches 410
    localparam int FALL_TICKS  = 258;    // Top passes 512

    typedef struct packed {
        int          frame;
        logic [3:0]  btn;
        score_t      score;
        judge_t      judge;
        game_state_t state;
    } row_t;

    localparam int N_ROWS = 8;
    localparam row_t ROWS [N_ROWS] = '{
        '{10, 4'b0100, 8'd0, JUDGE_MISS, GAME_ACTIVE},                           // Mis-press
        '{FIRST_SPAWN + HIT_TICKS, 4'b0001, 8'd2, JUDGE_PERFECT, GAME_ACTIVE},
        '{FIRST_SPAWN + HIT_TICKS + 7, 4'b0001, 8'd0, JUDGE_MISS, GAME_ACTIVE},
        '{FIRST_SPAWN + 2 * SPAWN_GAP + HIT_TICKS, 4'b0100, 8'd2, JUDGE_PERFECT, GAME_ACTIVE},
        '{FIRST_SPAWN + SPAWN_GAP + FALL_TICKS, 4'b0000, 8'd0, JUDGE_MISS, GAME_ACTIVE},
        '{FIRST_SPAWN + 3 * SPAWN_GAP + FALL_TICKS, 4'b0000, 8'd0, JUDGE_MISS, GAME_ACTIVE},
        '{MAX_FRAMES - 1, 4'b0000, 8'd0, JUDGE_MISS, GAME_ACTIVE},
        '{MAX_FRAMES, 4'b0000, 8'd0, JUDGE_MISS, GAME_LOST}                      // Timeout
    };

    logic         pix_clk;
    logic         reset;
    logic [3:0]   btn;
    vga_out_t     vga;
    game_status_t status;
    int           frame_cnt;
    logic         vsync_q;
    int           n_checks;
    int           n_errors;
    int           n_tests;
    int           n_failed;

    initial pix_clk = 1'b0;
    always #20 pix_clk = ~pix_clk;

    rhythm_top #(
        .h_visible(H_VISIBLE), .h_front(PORCH), .h_sync(SYNC_W), .h_back(PORCH),
        .v_visible(V_VISIBLE), .v_front(PORCH), .v_sync(SYNC_W), .v_back(PORCH),
        .max_frames(MAX_FRAMES)
    ) i_dut (
        .pix_clk(pix_clk), .reset(reset), .btn_i(btn), .vga_o(vga), .status_o(status)
    );

    // One vsync fall per frame
    always @(negedge pix_clk) begin
        if (reset) begin
            frame_cnt <= 0;
            vsync_q   <= 1'b1;
        end else begin
            vsync_q <= vga.vsync_n;
            if (vsync_q && !vga.vsync_n)
                frame_cnt <= frame_cnt + 1;
        end
    end

    // ==============================
    // Helpers
    // ==============================
    task automatic abort_run(input string what);
        $display("timeout at %0t ns while waiting for %s", $time, what);
        $display("TEST FAIL");
        $finish;
    endtask

    task automatic compare_value(input string name, input int got, input int exp);
        n_checks++;
        if (got != exp) begin
            n_errors++;
            $display("error at %0t ns: %s expected %0d, got %0d", $time, name, exp, got);
        end
    endtask

    function automatic logic sync_bit(input int sel);
        case (sel)
            0:       return vga.hsync_n;
            1:       return vga.vsync_n;
            default: return vga.blank_n;
        endcase
    endfunction

    task automatic wait_transition(input int sel, input logic level, input string what);
        logic prev;
        @(negedge pix_clk);
        prev = sync_bit(sel);
        for (int guard = 0; guard < 2 * FRAME_CYCLES; guard++) begin
            @(negedge pix_clk);
            if (prev != level && sync_bit(sel) == level)
                return;
            prev = sync_bit(sel);
        end
        abort_run(what);
    endtask

    task automatic count_level(input int sel, input logic level, output int cycles);
        cycles = 1;
        for (int guard = 0; guard < 2 * FRAME_CYCLES; guard++) begin
            @(negedge pix_clk);
            if (sync_bit(sel) != level)
                return;
            cycles++;
        end
        abort_run("the end of a sync or blank level");
    endtask

    task automatic wait_frame(input int target);
        int limit;
        limit = (target - frame_cnt + 2) * FRAME_CYCLES;
        for (int guard = 0; guard < limit; guard++) begin
            if (frame_cnt >= target)
                return;
            @(negedge pix_clk);
        end
        abort_run($sformatf("frame %0d", target));
    endtask

    task automatic drive_buttons(input logic [3:0] mask);
        @(posedge pix_clk);
        #5;
        btn = mask;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        n_tests++;
        if (n_errors == errs_before) begin
            $display("%s: ok", name);
        end else begin
            n_failed++;
            $display("%s: %0d errors", name, n_errors - errs_before);
        end
    endtask

    // ==============================
    // Tests
    // ==============================
    task automatic check_sync_timing();
        int   errs;
        int   width;
        int   high;
        int   visible;
        int   rises;
        logic prev;
        errs = n_errors;
        wait_transition(0, 1'b0, "an hsync pulse");
        count_level(0, 1'b0, width);
        compare_value("hsync_n low cycles", width, SYNC_W);
        count_level(0, 1'b1, high);
        compare_value("hsync_n period", width + high, H_TOTAL);
        wait_transition(1, 1'b0, "a vsync pulse");
        count_level(1, 1'b0, width);
        compare_value("vsync_n low cycles", width, SYNC_W * H_TOTAL);
        wait_transition(2, 1'b1, "the start of a frame");
        visible = 0;
        rises   = 0;
        prev    = 1'b0;
        for (int i = 0; i < FRAME_CYCLES; i++) begin
            if (i > 0)
                @(negedge pix_clk);
            if (vga.blank_n)
                visible++;
            if (vga.blank_n && !prev)
                rises++;
            prev = vga.blank_n;
        end
        compare_value("blank_n high cycles", visible, H_VISIBLE * V_VISIBLE);
        compare_value("blank_n visible lines", rises, V_VISIBLE);
        finish_test("sync timing", errs);
    endtask

    task automatic apply_row(input int idx);
        row_t row;
        int   errs;
        row  = ROWS[idx];
        errs = n_errors;
        wait_frame(row.frame);
        drive_buttons(row.btn);                          // Sampled at the coming tick
        wait_transition(2, 1'b1, "the frame tick");
        repeat (3) @(negedge pix_clk);
        compare_value("status_o.score", int'(status.score), int'(row.score));
        compare_value("status_o.last_judge", int'(status.last_judge), int'(row.judge));
        compare_value("status_o.state", int'(status.state), int'(row.state));
        drive_buttons(4'b0000);
        finish_test($sformatf("row %0d, frame %0d", idx, row.frame), errs);
    endtask

    task automatic check_end_screen();
        int   errs;
        int   col;
        int   line;
        logic in_view;
        rgb_t expected;
        errs = n_errors;
        // Sweep starts on the first line after the vsync pulse
        wait_transition(1, 1'b1, "the end of a vsync pulse");
        for (int i = 0; i < FRAME_CYCLES; i++) begin
            if (i > 0)
                @(negedge pix_clk);
            col      = i % H_TOTAL;
            line     = (V_VISIBLE + PORCH + SYNC_W + i / H_TOTAL) % V_TOTAL;
            in_view  = (col < H_VISIBLE) && (line < V_VISIBLE);
            expected = in_view ? rgb_t'(24'hff0000) : rgb_t'(24'h000000);
            n_checks++;
            if (vga.rgb != expected) begin
                n_errors++;
                if (n_errors - errs <= 4)
                    $display("error at %0t ns: vga_o.rgb expected %06h, got %06h",
                             $time, expected, vga.rgb);
            end
        end
        finish_test("end screen", errs);
    endtask

    initial begin
        reset    = 1'b1;
        btn      = 4'b0000;
        n_checks = 0;
        n_errors = 0;
        n_tests  = 0;
        n_failed = 0;
        repeat (8) @(posedge pix_clk);
        #5;
        reset = 1'b0;
        check_sync_timing();
        for (int i = 0; i < N_ROWS; i++)
            apply_row(i);
        check_end_screen();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 n_tests, n_failed, n_checks, n_errors);
        if (n_errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== files.f ====
rtl/vga_pkg.sv
rtl/game_pkg.sv
rtl/vga_timing.sv
rtl/game_timer.sv
rtl/note_field.sv
rtl/score_keeper.sv
rtl/pixel_render.sv
rtl/rhythm_top.sv
verif/rhythm_assertions.sv
verif/rhythm_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rhythm_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run check clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@$(MAKE) --no-print-directory check

check:
	@test -f $(LOG) || { echo "no log file, run the simulation first"; exit 1; }
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || { echo "simulation did not complete"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
